//--- link_sender.f
+incdir+testbench
src/link_pkg.sv
src/lane_shifter.sv
src/frame_builder.sv
src/data_send_fsm.sv
src/hnd_send_fsm.sv
src/link_sender.sv
testbench/link_sender_tb.sv

//--- Bender.yml
package:
  name: link_sender

sources:
  # design
  - src/link_pkg.sv
  - src/lane_shifter.sv
  - src/frame_builder.sv
  - src/data_send_fsm.sv
  - src/hnd_send_fsm.sv
  - src/link_sender.sv

  # testbench, top module link_sender_tb
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/link_sender_tb.sv

//--- testbench/link_sender_model.svh
// ####################
// reference model for link_sender, included inside the testbench module
// relies on the testbench's snapshot variables and lfsr_state
// ####################
`ifndef LINK_SENDER_MODEL_SVH
`define LINK_SENDER_MODEL_SVH

// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	logic fb;
	v = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		v = {v[30:0], fb};
	end
	return v;
endfunction

// nine tile kinds, so fold the nibble
function automatic tile_t random_tile();
	logic [3:0] v;
	v = 4'(rand_bits(TILE_BITS) % 9);
	return tile_t'(v);
endfunction

// packet built field by field from the top, shifting in nibbles
function automatic logic [PKT_BITS-1:0] model_packet(input logic seq);
	logic [PKT_BITS-1:0] p;
	p = '0;
	for (int i = 0; i < SEQ_COPIES; i++)
		p = {p[PKT_BITS-2:0], seq};
	p = {p[PKT_BITS-GBG_BITS-1:0], garbage};
	p = {p[PKT_BITS-TILE_BITS-1:0], hold};
	// highest queue entry first so entry 0 ends low
	for (int q = QUEUE_LEN - 1; q >= 0; q--)
		p = {p[PKT_BITS-TILE_BITS-1:0], piece_queue[q]};
	// last row, last column first, r0 c0 ends lowest
	for (int r = PF_ROWS - 1; r >= 0; r--)
		for (int c = PF_COLS - 1; c >= 0; c--)
			p = {p[PKT_BITS-TILE_BITS-1:0], playfield[r][c]};
	return p;
endfunction

// ack 1 s 0 ~s, game lost 0 s 1 ~s
function automatic logic [HND_BITS-1:0] hnd_word(input logic is_ack, input logic s);
	if (is_ack)
		return {1'b1, s, 1'b0, ~s};
	return {1'b0, s, 1'b1, ~s};
endfunction

`endif

//--- testbench/link_sender_tb.sv
// ####################
// random snapshots from a fixed lfsr seed, checked against the model
// outputs sampled on the falling edge, inputs driven 2 ns after rising
// ####################
`timescale 1ns/1ps

module link_sender_tb;
	import link_pkg::*;

	// six tests of a few frames and ~70 cycle timeouts, wide margin
	localparam int MAX_CYCLES = 6000;

	logic clk, rst_l, game_active, update_data;
	logic [GBG_BITS-1:0] garbage;
	tile_t hold;
	tile_t piece_queue [QUEUE_LEN];
	tile_t playfield [PF_ROWS][PF_COLS];
	logic send_ready_ack, send_game_lost, ack_received, ack_seq;
	logic serial_out_h, serial_out_0, serial_out_1, serial_out_2, serial_out_3;
	logic send_done, send_done_h, sender_seq;

	logic [31:0] lfsr_state;
	int cycle = 0;
	int errors, passed, failed, t0;
	logic exp_seq, found, req_ack, req_lost, s;
	logic [PKT_BITS-1:0] got, exp_a, exp_b;
	logic [HND_BITS-1:0] got_h;

	`include "link_sender_model.svh"

	link_sender dut (
		.clk(clk), .rst_l(rst_l), .game_active(game_active), .update_data(update_data),
		.garbage(garbage), .hold(hold), .piece_queue(piece_queue), .playfield(playfield),
		.send_ready_ack(send_ready_ack), .send_game_lost(send_game_lost),
		.ack_received(ack_received), .ack_seq(ack_seq), .serial_out_h(serial_out_h),
		.serial_out_0(serial_out_0), .serial_out_1(serial_out_1),
		.serial_out_2(serial_out_2), .serial_out_3(serial_out_3),
		.send_done(send_done), .send_done_h(send_done_h), .sender_seq(sender_seq)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// watchdog
	always @(posedge clk) begin
		cycle = cycle + 1;
		if (cycle >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic report_mismatch(input string name, input logic [PKT_BITS-1:0] got_v,
			input logic [PKT_BITS-1:0] exp_v);
		$display("Mismatch %s: got %h expected %h", name, got_v, exp_v);
		errors++;
	endtask

	task automatic new_snapshot();
		garbage = GBG_BITS'(rand_bits(GBG_BITS));
		hold = random_tile();
		for (int q = 0; q < QUEUE_LEN; q++)
			piece_queue[q] = random_tile();
		for (int r = 0; r < PF_ROWS; r++)
			for (int c = 0; c < PF_COLS; c++)
				playfield[r][c] = random_tile();
	endtask

	// t is the edge after which update_data goes high
	task automatic pulse_update(output int t);
		next_cycle();
		t = cycle;
		new_snapshot();
		update_data = 1'b1;
		next_cycle();
		update_data = 1'b0;
	endtask

	task automatic pulse_ack();
		next_cycle();
		ack_received = 1'b1;
		next_cycle();
		ack_received = 1'b0;
		exp_seq = ~exp_seq;
		@(negedge clk);
		if (sender_seq !== exp_seq)
			report_mismatch("sender_seq", sender_seq, exp_seq);
	endtask

	// waits for the shared start bit, then gathers one slice per lane
	task automatic capture_data(input int max_wait, output logic [PKT_BITS-1:0] pkt,
			output logic hit);
		logic [LANE_BITS-1:0] s0, s1, s2, s3;
		int n;
		hit = 1'b0;
		pkt = '0;
		n = 0;
		while (!hit && n < max_wait) begin
			@(negedge clk);
			n++;
			hit = serial_out_0 | serial_out_1 | serial_out_2 | serial_out_3;
		end
		if (!hit) begin
			$display("no start bit on the data lanes within %0d cycles", max_wait);
			errors++;
		end else begin
			if ({serial_out_3, serial_out_2, serial_out_1, serial_out_0} !== 4'hf)
				report_mismatch("data lane start bits",
					{serial_out_3, serial_out_2, serial_out_1, serial_out_0}, 4'hf);
			for (n = 0; n < LANE_BITS; n++) begin
				@(negedge clk);
				s0 = {s0[LANE_BITS-2:0], serial_out_0};
				s1 = {s1[LANE_BITS-2:0], serial_out_1};
				s2 = {s2[LANE_BITS-2:0], serial_out_2};
				s3 = {s3[LANE_BITS-2:0], serial_out_3};
			end
			pkt = {s0, s1, s2, s3};
		end
	endtask

	task automatic capture_hnd(input int max_wait, output logic [HND_BITS-1:0] w,
			output logic hit);
		int n;
		hit = 1'b0;
		w = '0;
		n = 0;
		while (!hit && n < max_wait) begin
			@(negedge clk);
			n++;
			hit = serial_out_h;
		end
		if (!hit) begin
			$display("no start bit on the handshake lane within %0d cycles", max_wait);
			errors++;
		end else begin
			for (n = 0; n < HND_BITS; n++) begin
				@(negedge clk);
				w = {w[HND_BITS-2:0], serial_out_h};
			end
		end
	endtask

	// every lane low and both done levels high for the whole window
	task automatic watch_idle(input int cycles);
		for (int n = 0; n < cycles; n++) begin
			@(negedge clk);
			if (serial_out_h | serial_out_0 | serial_out_1 | serial_out_2 | serial_out_3) begin
				$display("a lane went high at cycle %0d while it should be idle", cycle);
				errors++;
			end
			if (!send_done || !send_done_h) begin
				$display("a done output was low at cycle %0d with nothing sent", cycle);
				errors++;
			end
		end
	endtask

	task automatic end_test(input int num, input string name);
		if (errors == 0) begin
			$display("test %0d %s: PASS", num, name);
			passed++;
		end else begin
			$display("test %0d %s: FAIL with %0d errors", num, name, errors);
			failed++;
		end
		errors = 0;
	endtask

	initial begin
		lfsr_state = 32'h997a_7036;
		rst_l = 1'b0;
		game_active = 1'b1;
		update_data = 1'b0;
		garbage = '0;
		hold = TILE_EMPTY;
		for (int q = 0; q < QUEUE_LEN; q++)
			piece_queue[q] = TILE_EMPTY;
		for (int r = 0; r < PF_ROWS; r++)
			for (int c = 0; c < PF_COLS; c++)
				playfield[r][c] = TILE_EMPTY;
		send_ready_ack = 1'b0;
		send_game_lost = 1'b0;
		ack_received = 1'b0;
		ack_seq = 1'b0;
		errors = 0;
		passed = 0;
		failed = 0;
		exp_seq = 1'b0;
		repeat (10) @(posedge clk);
		#2 rst_l = 1'b1;

		// reset values, then one frame and its exact length
		@(negedge clk);
		if ({send_done, send_done_h, sender_seq} !== 3'b110)
			report_mismatch("send_done send_done_h sender_seq",
				{send_done, send_done_h, sender_seq}, 3'b110);
		pulse_update(t0);
		exp_a = model_packet(exp_seq);
		capture_data(10, got, found);
		if (found && got !== exp_a)
			report_mismatch("data packet", got, exp_a);
		while (!send_done && cycle < t0 + 40)
			@(negedge clk);
		if (cycle - t0 != 26)
			report_mismatch("send_done delay", cycle - t0, 26);
		pulse_ack();
		end_test(1, "data frame");

		// unacked frame comes again, then stays quiet after the ack
		pulse_update(t0);
		exp_a = model_packet(exp_seq);
		capture_data(10, got, found);
		if (found && got !== exp_a)
			report_mismatch("data packet", got, exp_a);
		capture_data(80, got, found);
		if (found && got !== exp_a)
			report_mismatch("resent data packet", got, exp_a);
		pulse_ack();
		watch_idle(100);
		end_test(2, "retransmit");

		// seq toggles on every ack, even with nothing outstanding
		pulse_ack();
		for (int k = 0; k < 3; k++) begin
			pulse_update(t0);
			exp_a = model_packet(exp_seq);
			capture_data(10, got, found);
			if (found && got[PKT_BITS-1 -: SEQ_COPIES] !== {SEQ_COPIES{exp_seq}})
				report_mismatch("sequence field", got[PKT_BITS-1 -: SEQ_COPIES],
					{SEQ_COPIES{exp_seq}});
			if (found && got !== exp_a)
				report_mismatch("data packet", got, exp_a);
			pulse_ack();
		end
		end_test(3, "sequence");

		// first request has both set to show ack winning
		for (int k = 0; k < 8; k++) begin
			{req_lost, req_ack} = 2'(rand_bits(2));
			if (k == 0)
				{req_lost, req_ack} = 2'b11;
			else if (!req_ack && !req_lost)
				req_lost = 1'b1;
			s = 1'(rand_bits(1));
			next_cycle();
			send_ready_ack = req_ack;
			send_game_lost = req_lost;
			ack_seq = s;
			next_cycle();
			send_ready_ack = 1'b0;
			send_game_lost = 1'b0;
			capture_hnd(10, got_h, found);
			if (found && got_h !== hnd_word(req_ack, s))
				report_mismatch("serial_out_h frame", got_h, hnd_word(req_ack, s));
		end
		end_test(4, "handshake encodings");

		// nothing may start, nor leak out once the game resumes
		next_cycle();
		game_active = 1'b0;
		pulse_update(t0);
		next_cycle();
		send_ready_ack = 1'b1;
		send_game_lost = 1'b1;
		next_cycle();
		send_ready_ack = 1'b0;
		send_game_lost = 1'b0;
		watch_idle(100);
		next_cycle();
		game_active = 1'b1;
		watch_idle(20);
		end_test(5, "inactive game");

		// second snapshot lands mid-frame and waits for the ack
		pulse_update(t0);
		exp_a = model_packet(exp_seq);
		fork
			capture_data(10, got, found);
			begin
				repeat (6) next_cycle();
				pulse_update(t0);
			end
		join
		if (found && got !== exp_a)
			report_mismatch("data packet", got, exp_a);
		capture_data(80, got, found);
		if (found && got !== exp_a)
			report_mismatch("resent data packet", got, exp_a);
		pulse_ack();
		exp_b = model_packet(exp_seq);
		capture_data(20, got, found);
		if (found && got !== exp_b)
			report_mismatch("second data packet", got, exp_b);
		pulse_ack();
		end_test(6, "overwrite while busy");

		$display("tests passed %0d failed %0d", passed, failed);
		if (failed == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- src/link_sender.sv
// ####################
// raw bits on every lane, no line coding
// all lanes run on clk and start on the same cycle
// lane 0 carries the top slice of the packet
// ####################
`timescale 1ns/1ps

module link_sender (
	input  logic                          clk,
	input  logic                          rst_l,
	input  logic                          game_active,
	input  logic                          update_data,
	input  logic [link_pkg::GBG_BITS-1:0] garbage,
	input  link_pkg::tile_t               hold,
	input  link_pkg::tile_t               piece_queue [link_pkg::QUEUE_LEN],
	input  link_pkg::tile_t               playfield [link_pkg::PF_ROWS][link_pkg::PF_COLS],
	input  logic                          send_ready_ack,
	input  logic                          send_game_lost,
	input  logic                          ack_received,
	input  logic                          ack_seq,
	output logic                          serial_out_h,
	output logic                          serial_out_0,
	output logic                          serial_out_1,
	output logic                          serial_out_2,
	output logic                          serial_out_3,
	output logic                          send_done,
	output logic                          send_done_h,
	output logic                          sender_seq
);
	import link_pkg::*;

	logic [PKT_BITS-1:0] data_packet;
	logic [HND_BITS-1:0] hnd_packet;
	logic data_ready;
	logic hnd_ready;
	logic hold_pkt;
	logic send_start;
	logic send_start_h;
	logic [LANES-1:0] lane_done;
	logic [LANES-1:0] lane_serial;

	frame_builder u_builder (
		.clk           (clk),
		.rst_l         (rst_l),
		.update_data   (update_data),
		.hold_pkt      (hold_pkt),
		.garbage       (garbage),
		.hold          (hold),
		.piece_queue   (piece_queue),
		.playfield     (playfield),
		.send_ready_ack(send_ready_ack),
		.send_game_lost(send_game_lost),
		.ack_seq       (ack_seq),
		.ack_received  (ack_received),
		.data_packet   (data_packet),
		.data_ready    (data_ready),
		.hnd_packet    (hnd_packet),
		.hnd_ready     (hnd_ready),
		.sender_seq    (sender_seq)
	);

	data_send_fsm u_data_fsm (
		.clk         (clk),
		.rst_l       (rst_l),
		.game_active (game_active),
		.data_ready  (data_ready),
		.ack_received(ack_received),
		.lanes_done  (send_done),
		.send_start  (send_start),
		.hold_pkt    (hold_pkt)
	);

	hnd_send_fsm u_hnd_fsm (
		.clk         (clk),
		.rst_l       (rst_l),
		.game_active (game_active),
		.hnd_ready   (hnd_ready),
		.lane_done   (send_done_h),
		.send_start_h(send_start_h)
	);

	// each data lane re-latches the frozen packet on every start
	for (genvar i = 0; i < LANES; i++) begin : g_lane
		lane_shifter #(.FRAME_BITS(LANE_BITS)) u_lane (
			.clk       (clk),
			.rst_l     (rst_l),
			.start     (send_start),
			.data_in   (data_packet[PKT_BITS-1-i*LANE_BITS -: LANE_BITS]),
			.done      (lane_done[i]),
			.serial_out(lane_serial[i])
		);
	end

	lane_shifter #(.FRAME_BITS(HND_BITS)) u_lane_h (
		.clk       (clk),
		.rst_l     (rst_l),
		.start     (send_start_h),
		.data_in   (hnd_packet),
		.done      (send_done_h),
		.serial_out(serial_out_h)
	);

	assign send_done = &lane_done;

	assign serial_out_0 = lane_serial[0];
	assign serial_out_1 = lane_serial[1];
	assign serial_out_2 = lane_serial[2];
	assign serial_out_3 = lane_serial[3];

endmodule

//--- src/hnd_send_fsm.sv
// ####################
// one request is kept pending while the lane is busy
// the builder keeps the newest handshake word
// ####################
`timescale 1ns/1ps

module hnd_send_fsm (
	input  logic clk,
	input  logic rst_l,
	input  logic game_active,
	input  logic hnd_ready,
	input  logic lane_done,
	output logic send_start_h
);
	import link_pkg::*;

	hnd_state_t state, state_next;
	logic pending;
	logic can_start;

	assign can_start = game_active && lane_done && (hnd_ready || pending);
	assign send_start_h = (state == HS_START);

	always_comb begin
		state_next = state;
		case (state)
			HS_IDLE: begin
				if (can_start)
					state_next = HS_START;
			end
			HS_START: state_next = HS_SENDING;
			HS_SENDING: begin
				if (lane_done)
					state_next = HS_IDLE;
			end
			default: state_next = HS_IDLE;
		endcase
		if (!game_active)
			state_next = HS_IDLE;
	end

	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			state   <= HS_IDLE;
			pending <= 1'b0;
		end else begin
			state <= state_next;
			if (!game_active)
				pending <= 1'b0;
			else if (state == HS_IDLE && can_start)
				pending <= 1'b0;
			// word loaded during START is latched by the lane anyway
			else if (hnd_ready && state != HS_START)
				pending <= 1'b1;
		end
	end

endmodule

//--- src/data_send_fsm.sv
// ####################
// resends after TIMEOUT_CYCLES in WAIT_ACK
// an ack during a frame is kept until the frame ends
// hold_pkt freezes the builder while a packet is outstanding
// ####################
`timescale 1ns/1ps

module data_send_fsm (
	input  logic clk,
	input  logic rst_l,
	input  logic game_active,
	input  logic data_ready,
	input  logic ack_received,
	input  logic lanes_done,
	output logic send_start,
	output logic hold_pkt
);
	import link_pkg::*;

	data_state_t state, state_next;
	logic [TIMEOUT_BITS-1:0] timeout_cnt;
	logic timeout;
	logic pending;
	logic ack_early;
	logic can_start;

	assign timeout = (timeout_cnt == TIMEOUT_CYCLES - 1'b1);
	// lanes must be free, a frame may still finish after a game stop
	assign can_start = game_active && lanes_done && (data_ready || pending);

	assign send_start = (state == DS_START);
	// fresh packet or one in flight keeps the register frozen
	assign hold_pkt = (state != DS_IDLE) || data_ready || pending;

	always_comb begin
		state_next = state;
		case (state)
			DS_IDLE: begin
				if (can_start)
					state_next = DS_START;
			end
			DS_START: state_next = DS_SENDING;
			DS_SENDING: begin
				if (lanes_done)
					state_next = (ack_early || ack_received) ? DS_IDLE : DS_WAIT_ACK;
			end
			DS_WAIT_ACK: begin
				if (ack_received)
					state_next = DS_IDLE;
				else if (timeout)
					state_next = DS_START;
			end
			default: state_next = DS_IDLE;
		endcase
		// inactive game parks the FSM
		if (!game_active)
			state_next = DS_IDLE;
	end

	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			state       <= DS_IDLE;
			timeout_cnt <= '0;
			pending     <= 1'b0;
			ack_early   <= 1'b0;
		end else begin
			state <= state_next;

			// counts only while staying in WAIT_ACK
			if (state == DS_WAIT_ACK && state_next == DS_WAIT_ACK)
				timeout_cnt <= timeout_cnt + 1'b1;
			else
				timeout_cnt <= '0;

			// packet that could not start right away
			if (!game_active)
				pending <= 1'b0;
			else if (state == DS_IDLE && can_start)
				pending <= 1'b0;
			else if (data_ready)
				pending <= 1'b1;

			// ack seen while the frame is still on the wire
			if (!game_active || (state_next != DS_START && state_next != DS_SENDING))
				ack_early <= 1'b0;
			else if (ack_received && (state == DS_START || state == DS_SENDING))
				ack_early <= 1'b1;
		end
	end

	// lanes must go busy right after they are started
	a_lanes_take_start: assert property (
		@(posedge clk) disable iff (!rst_l)
		send_start |=> !lanes_done
	) else $error("data_send_fsm: lanes did not start after send_start");

	a_start_lanes_free: assert property (
		@(posedge clk) disable iff (!rst_l)
		send_start |-> lanes_done
	) else $error("data_send_fsm: send_start with lanes busy");

endmodule

//--- src/frame_builder.sv
// ####################
// packet register is frozen while hold_pkt is high
// one snapshot is parked in a shadow, newest wins
// seq field is rebuilt whenever the register loads
// ####################
`timescale 1ns/1ps

module frame_builder (
	input  logic                          clk,
	input  logic                          rst_l,
	input  logic                          update_data,
	input  logic                          hold_pkt,
	input  logic [link_pkg::GBG_BITS-1:0] garbage,
	input  link_pkg::tile_t               hold,
	input  link_pkg::tile_t               piece_queue [link_pkg::QUEUE_LEN],
	input  link_pkg::tile_t               playfield [link_pkg::PF_ROWS][link_pkg::PF_COLS],
	input  logic                          send_ready_ack,
	input  logic                          send_game_lost,
	input  logic                          ack_seq,
	input  logic                          ack_received,
	output logic [link_pkg::PKT_BITS-1:0] data_packet,
	output logic                          data_ready,
	output logic [link_pkg::HND_BITS-1:0] hnd_packet,
	output logic                          hnd_ready,
	output logic                          sender_seq
);
	import link_pkg::*;

	logic [QUEUE_LEN*TILE_BITS-1:0] queue_flat;
	logic [PF_ROWS*PF_COLS*TILE_BITS-1:0] field_flat;
	logic [PAYLOAD_BITS-1:0] payload;
	logic [PAYLOAD_BITS-1:0] shadow;
	logic shadow_valid;
	logic seq_next;
	logic load_now;
	logic copy_now;

	// queue entry 0 lands in the low nibble
	// playfield row-major, r0 c0 lowest
	always_comb begin
		for (int q = 0; q < QUEUE_LEN; q++) begin
			queue_flat[q*TILE_BITS +: TILE_BITS] = piece_queue[q];
		end
		for (int r = 0; r < PF_ROWS; r++) begin
			for (int c = 0; c < PF_COLS; c++) begin
				field_flat[(r*PF_COLS + c)*TILE_BITS +: TILE_BITS] = playfield[r][c];
			end
		end
	end

	assign payload = {garbage, hold, queue_flat, field_flat};

	// value seq takes after this edge
	assign seq_next = sender_seq ^ ack_received;

	// direct load when the sender is free
	assign load_now = update_data && !hold_pkt;
	// parked snapshot moves in once the hold drops
	assign copy_now = shadow_valid && !hold_pkt && !update_data;

	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			sender_seq   <= 1'b0;
			shadow_valid <= 1'b0;
			data_ready   <= 1'b0;
		end else begin
			sender_seq <= seq_next;
			data_ready <= load_now || copy_now;
			if (load_now || copy_now)
				shadow_valid <= 1'b0;
			else if (update_data)
				shadow_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (load_now)
			data_packet <= {{SEQ_COPIES{seq_next}}, payload};
		else if (copy_now)
			data_packet <= {{SEQ_COPIES{seq_next}}, shadow};
		// shadow only written while frozen
		if (update_data && hold_pkt)
			shadow <= payload;
	end

	// handshake word, ack beats game lost
	always_ff @(posedge clk) begin
		if (send_ready_ack)
			hnd_packet <= {1'b1, ack_seq, 1'b0, ~ack_seq};
		else if (send_game_lost)
			hnd_packet <= {1'b0, ack_seq, 1'b1, ~ack_seq};
	end

	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l)
			hnd_ready <= 1'b0;
		else
			hnd_ready <= send_ready_ack || send_game_lost;
	end

endmodule

//--- src/lane_shifter.sv
// ####################
// lane idles low, sends a 1 start bit then data MSB first
// data is latched on start so later input changes are safe
// start must only come while done is high
// ####################
`timescale 1ns/1ps

module lane_shifter #(
	parameter int FRAME_BITS = link_pkg::LANE_BITS
) (
	input  logic                  clk,
	input  logic                  rst_l,
	input  logic                  start,
	input  logic [FRAME_BITS-1:0] data_in,
	output logic                  done,
	output logic                  serial_out
);
	localparam int CNT_BITS = $clog2(FRAME_BITS + 1);

	logic [FRAME_BITS-1:0] shift_reg;
	// data bits still to go out
	logic [CNT_BITS-1:0] bit_cnt;

	always_ff @(posedge clk, negedge rst_l) begin
		if (!rst_l) begin
			done       <= 1'b1;
			serial_out <= 1'b0;
			bit_cnt    <= '0;
		end else if (start) begin
			// start bit goes out next cycle
			serial_out <= 1'b1;
			bit_cnt    <= CNT_BITS'(FRAME_BITS);
			done       <= 1'b0;
		end else if (!done) begin
			if (bit_cnt != '0) begin
				serial_out <= shift_reg[FRAME_BITS-1];
				bit_cnt    <= bit_cnt - 1'b1;
			end else begin
				// last bit was on the wire this cycle
				serial_out <= 1'b0;
				done       <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			shift_reg <= data_in;
		else if (!done && bit_cnt != '0)
			shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b0};
	end

	// control must never restart a frame mid-flight
	a_start_when_done: assert property (
		@(posedge clk) disable iff (!rst_l)
		start |-> done
	) else $error("lane_shifter: start while frame in flight");

endmodule

//--- src/link_pkg.sv
// ####################
// sizes for the scaled-down 4x4 playfield build
// changing the tile count moves the lane slice width
// PKT_BITS must stay a multiple of LANES
// ####################

package link_pkg;

	// tile kinds, one nibble each on the wire
	typedef enum logic [3:0] {
		TILE_EMPTY   = 4'd0,
		TILE_I       = 4'd1,
		TILE_O       = 4'd2,
		TILE_T       = 4'd3,
		TILE_S       = 4'd4,
		TILE_Z       = 4'd5,
		TILE_J       = 4'd6,
		TILE_L       = 4'd7,
		TILE_GARBAGE = 4'd8
	} tile_t;

	localparam int TILE_BITS = 4;

	// playfield and queue dimensions
	localparam int PF_ROWS = 4;
	localparam int PF_COLS = 4;
	localparam int QUEUE_LEN = 3;

	// garbage line count
	localparam int GBG_BITS = 4;

	// seq bit is sent four times for robustness
	localparam int SEQ_COPIES = 4;

	// everything below the sequence field
	localparam int PAYLOAD_BITS = GBG_BITS + TILE_BITS + QUEUE_LEN * TILE_BITS
		+ PF_ROWS * PF_COLS * TILE_BITS;

	localparam int PKT_BITS = SEQ_COPIES + PAYLOAD_BITS;

	// data lanes and per-lane slice
	localparam int LANES = 4;
	localparam int LANE_BITS = PKT_BITS / LANES;

	// handshake word: type bit, seq, type bit, inverted seq
	localparam int HND_BITS = 4;

	// ack wait before a resend, counted in clk cycles
	localparam int TIMEOUT_BITS = 8;
	localparam logic [TIMEOUT_BITS-1:0] TIMEOUT_CYCLES = 8'd40;

	// data lane control
	typedef enum logic [1:0] {
		DS_IDLE,
		DS_START,
		DS_SENDING,
		DS_WAIT_ACK
	} data_state_t;

	// handshake lane control
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_START,
		HS_SENDING
	} hnd_state_t;

endpackage
